//--- dma_cfg.svh
// Sample mover configuration
// Channel count, bus timing, address map, widths and the fixed channel orders

`ifndef DMA_CFG_SVH
`define DMA_CFG_SVH

`define CHANNEL_NUMBER 3
`define SB_DELAY 5

// Source channel k sits at BASE_ADDRESS + (k - 1) * CHANNEL_OFFSET
`define BASE_ADDRESS 32'h43c0_0000
`define CHANNEL_OFFSET 32'h4
`define TARGET_ADDRESS 8'h18

`define SAMPLE_WIDTH 16
`define BUS_ADDR_WIDTH 32
`define DEST_WIDTH 8

// Position i reads source SOURCE_SEQ_i and writes target TARGET_SEQ_i (1-based)
`define SOURCE_SEQ_0 3
`define SOURCE_SEQ_1 1
`define SOURCE_SEQ_2 2
`define TARGET_SEQ_0 2
`define TARGET_SEQ_1 3
`define TARGET_SEQ_2 1

`endif

//--- dma_pkg.sv
// Shared types of the sample mover
// Stream beat word and the DMA controller state

`default_nettype none

`include "dma_cfg.svh"

package dma_pkg;

    // Register address field of a beat word
    typedef logic [7:0] reg_address_t;

    // The sender fills the raw view, the target bank decodes the fields view
    typedef union packed {
        logic [8+`SAMPLE_WIDTH-1:0] raw;
        struct packed {
            reg_address_t reg_address;
            logic [`SAMPLE_WIDTH-1:0] value;
        } fields;
    } stream_word_t;

    // Per-channel steps of an active frame
    typedef enum logic [1:0] {
        idle,
        read_source,
        wait_bus
    } dma_state_t;

endpackage

`default_nettype wire

//--- channel_registers.sv
// Source register bank with one sample per channel
// Read over the simple bus through a two-stage pipeline

`timescale 1ns/10ps
`default_nettype none

`include "dma_cfg.svh"

module channel_registers (
    input wire clock,
    input wire reset,
    input wire sample_write,
    input wire [1:0] sample_channel,
    input wire [`SAMPLE_WIDTH-1:0] sample_value,
    input wire [`BUS_ADDR_WIDTH-1:0] sb_address,
    input wire sb_read_strobe,
    output logic sb_ready,
    output logic [`SAMPLE_WIDTH-1:0] sb_read_data
);

    logic [`SAMPLE_WIDTH-1:0] samples [`CHANNEL_NUMBER];
    logic [`BUS_ADDR_WIDTH-1:0] address_offset;
    logic [`BUS_ADDR_WIDTH-1:0] address_slot;
    logic address_hit;
    logic read_pending;
    logic read_hit;
    logic [1:0] read_slot;
    logic data_pending;

    // sample_channel is the 0-based slot, so source channel k uses slot k - 1
    assign address_offset = sb_address - `BASE_ADDRESS;
    assign address_slot = address_offset / `CHANNEL_OFFSET;
    assign address_hit = address_slot < `CHANNEL_NUMBER;

    assign sb_ready = ~(read_pending | data_pending);

    always_ff @(posedge clock) begin
        if (!reset) begin
            for (int i = 0; i < `CHANNEL_NUMBER; i++) begin
                samples[i] <= '0;
            end
        end else if (sample_write && sample_channel < `CHANNEL_NUMBER) begin
            samples[sample_channel] <= sample_value;
        end
    end

    // First stage latches the decoded slot, second stage returns the data
    always_ff @(posedge clock) begin
        if (!reset) begin
            read_pending <= 1'b0;
            data_pending <= 1'b0;
            read_hit <= 1'b0;
            read_slot <= '0;
            sb_read_data <= '0;
        end else begin
            read_pending <= sb_read_strobe;
            data_pending <= read_pending;
            if (sb_read_strobe) begin
                read_hit <= address_hit;
                read_slot <= address_slot[1:0];
            end
            if (read_pending) begin
                sb_read_data <= read_hit ? samples[read_slot] : '0;
            end
        end
    end

    // The master must wait for the pipeline to drain before the next read
    strobe_only_when_ready: assert property (
        @(posedge clock) disable iff (!reset) sb_read_strobe |-> sb_ready
    );

endmodule

`default_nettype wire

//--- address_sequencer.sv
// Channel index counter of the DMA master
// Maps the index to the source bus address and the target destination

`timescale 1ns/10ps
`default_nettype none

`include "dma_cfg.svh"

module address_sequencer (
    input wire clock,
    input wire reset,
    input wire seq_clear,
    input wire seq_step,
    output logic [`BUS_ADDR_WIDTH-1:0] sb_address,
    output logic [`DEST_WIDTH-1:0] target_dest,
    output logic last_channel
);

    logic [1:0] channel_index;
    logic [`BUS_ADDR_WIDTH-1:0] source_channel;
    logic [`DEST_WIDTH-1:0] target_channel;

    // Fixed channel orders, both 1-based
    always_comb begin
        case (channel_index)
            2'd0: source_channel = `BUS_ADDR_WIDTH'(`SOURCE_SEQ_0);
            2'd1: source_channel = `BUS_ADDR_WIDTH'(`SOURCE_SEQ_1);
            default: source_channel = `BUS_ADDR_WIDTH'(`SOURCE_SEQ_2);
        endcase
        case (channel_index)
            2'd0: target_channel = `DEST_WIDTH'(`TARGET_SEQ_0);
            2'd1: target_channel = `DEST_WIDTH'(`TARGET_SEQ_1);
            default: target_channel = `DEST_WIDTH'(`TARGET_SEQ_2);
        endcase
    end

    assign last_channel = channel_index == 2'(`CHANNEL_NUMBER);

    always_ff @(posedge clock) begin
        if (!reset || seq_clear) begin
            channel_index <= '0;
        end else if (seq_step) begin
            channel_index <= channel_index + 2'd1;
        end
    end

    // Address and destination of the channel being read stay put until the next step
    always_ff @(posedge clock) begin
        if (!reset) begin
            sb_address <= '0;
            target_dest <= '0;
        end else if (seq_step) begin
            sb_address <= `BASE_ADDRESS + (source_channel - 1) * `CHANNEL_OFFSET;
            target_dest <= target_channel;
        end
    end

    no_step_past_last: assert property (
        @(posedge clock) disable iff (!reset) seq_step |-> channel_index < `CHANNEL_NUMBER
    );

endmodule

`default_nettype wire

//--- dma_control.sv
// DMA master controller
// Runs one frame per enable and walks each channel through read, bus wait and beat

`timescale 1ns/10ps
`default_nettype none

`include "dma_cfg.svh"

module dma_control (
    input wire clock,
    input wire reset,
    input wire enable,
    input wire sb_ready,
    input wire stream_ready,
    input wire last_channel,
    output logic sb_read_strobe,
    output logic seq_clear,
    output logic seq_step,
    output logic capture,
    output logic frame_done
);

    import dma_pkg::*;

    localparam int WAIT_WIDTH = $clog2(`SB_DELAY);

    logic active;
    dma_state_t state;
    logic [WAIT_WIDTH-1:0] wait_counter;
    logic wait_done;

    assign wait_done = wait_counter == WAIT_WIDTH'(`SB_DELAY - 1);

    // The index is held at zero between frames
    assign seq_clear = ~active;

    // A read starts only when both the bus and the sink can take it
    assign seq_step = active && state == idle && stream_ready && sb_ready;

    assign capture = active && state == wait_bus && wait_done;

    always_ff @(posedge clock) begin
        if (!reset) begin
            active <= 1'b0;
            state <= idle;
            wait_counter <= '0;
            sb_read_strobe <= 1'b0;
            frame_done <= 1'b0;
        end else begin
            sb_read_strobe <= seq_step;
            // Lines up with the last beat leaving the packer
            frame_done <= capture && last_channel;
            if (!active) begin
                state <= idle;
                wait_counter <= '0;
                active <= enable;
            end else begin
                case (state)
                    idle: begin
                        if (seq_step) begin
                            state <= read_source;
                        end
                    end
                    read_source: begin
                        state <= wait_bus;
                    end
                    wait_bus: begin
                        if (wait_done) begin
                            state <= idle;
                            wait_counter <= '0;
                            if (last_channel) begin
                                active <= 1'b0;
                            end
                        end else begin
                            wait_counter <= wait_counter + 1'b1;
                        end
                    end
                    default: begin
                        state <= idle;
                        active <= 1'b0;
                    end
                endcase
            end
        end
    end

    // A beat is always preceded by a read exactly one bus delay earlier
    capture_after_full_wait: assert property (
        @(posedge clock) disable iff (!reset)
        capture |-> state == wait_bus && $past(state, `SB_DELAY) == read_source
    );

endmodule

`default_nettype wire

//--- stream_packer.sv
// Stream beat builder
// Packs the read sample behind the target address and pulses valid for one cycle

`timescale 1ns/10ps
`default_nettype none

`include "dma_cfg.svh"

module stream_packer (
    input wire clock,
    input wire reset,
    input wire capture,
    input wire [`SAMPLE_WIDTH-1:0] sb_read_data,
    input wire [`DEST_WIDTH-1:0] target_dest,
    input wire last_channel,
    output dma_pkg::stream_word_t stream_data,
    output logic [`DEST_WIDTH-1:0] stream_dest,
    output logic stream_valid,
    output logic stream_last
);

    // No ready hold here, the sink has to take the beat in its valid cycle
    always_ff @(posedge clock) begin
        if (!reset) begin
            stream_data <= '0;
            stream_dest <= '0;
            stream_valid <= 1'b0;
            stream_last <= 1'b0;
        end else if (capture) begin
            stream_data.raw <= {`TARGET_ADDRESS, sb_read_data};
            stream_dest <= target_dest;
            stream_valid <= 1'b1;
            stream_last <= last_channel;
        end else begin
            // Bus outputs return to zero between beats
            stream_data <= '0;
            stream_dest <= '0;
            stream_valid <= 1'b0;
            stream_last <= 1'b0;
        end
    end

endmodule

`default_nettype wire

//--- target_registers.sv
// Target register bank fed by the stream
// Stores each accepted beat per destination channel with a registered readout

`timescale 1ns/10ps
`default_nettype none

`include "dma_cfg.svh"

module target_registers (
    input wire clock,
    input wire reset,
    input wire hold,
    input wire dma_pkg::stream_word_t stream_data,
    input wire [`DEST_WIDTH-1:0] stream_dest,
    input wire stream_valid,
    input wire stream_last,
    input wire [1:0] read_channel,
    output logic stream_ready,
    output logic [`SAMPLE_WIDTH-1:0] read_value
);

    logic [`SAMPLE_WIDTH-1:0] stored [`CHANNEL_NUMBER];
    logic [`DEST_WIDTH-1:0] store_slot;
    logic dest_in_range;
    logic accept;
    logic [1:0] beat_count;

    assign stream_ready = ~hold;

    // Destinations are 1-based on the stream
    assign store_slot = stream_dest - `DEST_WIDTH'(1);
    assign dest_in_range = stream_dest >= `DEST_WIDTH'(1)
        && stream_dest <= `DEST_WIDTH'(`CHANNEL_NUMBER);

    // Every valid beat is taken, but only ones for this bank are stored
    assign accept = stream_valid && dest_in_range
        && stream_data.fields.reg_address == `TARGET_ADDRESS;

    always_ff @(posedge clock) begin
        if (!reset) begin
            for (int i = 0; i < `CHANNEL_NUMBER; i++) begin
                stored[i] <= '0;
            end
        end else if (accept) begin
            stored[store_slot[1:0]] <= stream_data.fields.value;
        end
    end

    always_ff @(posedge clock) begin
        if (!reset) begin
            read_value <= '0;
        end else begin
            read_value <= read_channel < `CHANNEL_NUMBER ? stored[read_channel] : '0;
        end
    end

    // Beat position inside the current frame
    always_ff @(posedge clock) begin
        if (!reset) begin
            beat_count <= '0;
        end else if (stream_valid) begin
            beat_count <= stream_last ? 2'd0 : beat_count + 2'd1;
        end
    end

    dest_within_bank: assert property (
        @(posedge clock) disable iff (!reset) stream_valid |-> dest_in_range
    );

    last_on_final_beat: assert property (
        @(posedge clock) disable iff (!reset)
        stream_valid |-> stream_last == (beat_count == 2'(`CHANNEL_NUMBER - 1))
    );

endmodule

`default_nettype wire

//--- sample_mover_top.sv
// Sample mover top level
// Source bank, DMA master blocks and target bank joined by the simple bus and stream

`timescale 1ns/10ps
`default_nettype none

`include "dma_cfg.svh"

module sample_mover_top (
    input wire clock,
    input wire reset,
    input wire enable,
    input wire hold,
    input wire sample_write,
    input wire [1:0] sample_channel,
    input wire [`SAMPLE_WIDTH-1:0] sample_value,
    input wire [1:0] read_channel,
    output wire frame_done,
    output wire stream_valid,
    output wire stream_last,
    output wire [`SAMPLE_WIDTH-1:0] read_value
);

    import dma_pkg::*;

    wire [`BUS_ADDR_WIDTH-1:0] sb_address;
    wire sb_read_strobe;
    wire sb_ready;
    wire [`SAMPLE_WIDTH-1:0] sb_read_data;
    wire seq_clear;
    wire seq_step;
    wire capture;
    wire last_channel;
    wire [`DEST_WIDTH-1:0] target_dest;
    stream_word_t stream_data;
    wire [`DEST_WIDTH-1:0] stream_dest;
    wire stream_ready;

    channel_registers i_channel_registers (
        .clock(clock), .reset(reset),
        .sample_write(sample_write), .sample_channel(sample_channel),
        .sample_value(sample_value), .sb_address(sb_address),
        .sb_read_strobe(sb_read_strobe), .sb_ready(sb_ready), .sb_read_data(sb_read_data)
    );

    address_sequencer i_address_sequencer (
        .clock(clock), .reset(reset), .seq_clear(seq_clear), .seq_step(seq_step),
        .sb_address(sb_address), .target_dest(target_dest), .last_channel(last_channel)
    );

    dma_control i_dma_control (
        .clock(clock), .reset(reset), .enable(enable), .sb_ready(sb_ready),
        .stream_ready(stream_ready), .last_channel(last_channel),
        .sb_read_strobe(sb_read_strobe), .seq_clear(seq_clear), .seq_step(seq_step),
        .capture(capture), .frame_done(frame_done)
    );

    stream_packer i_stream_packer (
        .clock(clock), .reset(reset), .capture(capture), .sb_read_data(sb_read_data),
        .target_dest(target_dest), .last_channel(last_channel),
        .stream_data(stream_data), .stream_dest(stream_dest),
        .stream_valid(stream_valid), .stream_last(stream_last)
    );

    target_registers i_target_registers (
        .clock(clock), .reset(reset), .hold(hold),
        .stream_data(stream_data), .stream_dest(stream_dest),
        .stream_valid(stream_valid), .stream_last(stream_last),
        .read_channel(read_channel), .stream_ready(stream_ready), .read_value(read_value)
    );

endmodule

`default_nettype wire

//--- tb_sample_mover.sv
// Testbench of the sample mover
// Random samples through single, back-to-back, held-off and interrupted frames

`timescale 1ns/10ps
`default_nettype none

`include "dma_cfg.svh"

module tb_sample_mover;

    typedef logic [`SAMPLE_WIDTH-1:0] sample_array_t [`CHANNEL_NUMBER];

    localparam int FRAME_TIMEOUT = 200;
    localparam int BEAT_TIMEOUT = 50;

    logic clock;
    logic reset;
    logic enable;
    logic hold;
    logic sample_write;
    logic [1:0] sample_channel;
    logic [`SAMPLE_WIDTH-1:0] sample_value;
    logic [1:0] read_channel;
    wire frame_done;
    wire stream_valid;
    wire stream_last;
    wire [`SAMPLE_WIDTH-1:0] read_value;

    logic [31:0] lfsr_state;
    sample_array_t source_samples;
    sample_array_t first_snapshot;
    int value_errors;
    int protocol_errors;
    int timeout_errors;
    int valid_count;
    int beats_in_frame;
    int count_before;

    sample_mover_top i_dut (
        .clock(clock), .reset(reset), .enable(enable), .hold(hold),
        .sample_write(sample_write), .sample_channel(sample_channel),
        .sample_value(sample_value), .read_channel(read_channel),
        .frame_done(frame_done), .stream_valid(stream_valid),
        .stream_last(stream_last), .read_value(read_value)
    );

    always #2 clock = ~clock;

    // Fibonacci LFSR with taps 32, 22, 2 and 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        logic feedback;
        feedback = state[31] ^ state[21] ^ state[1] ^ state[0];
        return {state[30:0], feedback};
    endfunction

    task automatic random_bits(input int count, output logic [31:0] bits);
        bits = '0;
        for (int i = 0; i < count; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            bits = {bits[30:0], lfsr_state[0]};
        end
    endtask

    // Position i moves source channel SOURCE_SEQ_i into target channel TARGET_SEQ_i
    function automatic logic [`SAMPLE_WIDTH-1:0] expected_target(
        input int target_channel, input sample_array_t samples);
        int source_order [`CHANNEL_NUMBER];
        int target_order [`CHANNEL_NUMBER];
        source_order = '{`SOURCE_SEQ_0, `SOURCE_SEQ_1, `SOURCE_SEQ_2};
        target_order = '{`TARGET_SEQ_0, `TARGET_SEQ_1, `TARGET_SEQ_2};
        for (int i = 0; i < `CHANNEL_NUMBER; i++) begin
            if (target_order[i] == target_channel) begin
                return samples[source_order[i] - 1];
            end
        end
        return '0;
    endfunction

    // Beat monitor, sampled on the rising edge where the stream outputs are stable
    always @(posedge clock) begin
        if (reset && stream_valid) begin
            valid_count <= valid_count + 1;
            if (stream_last) begin
                assert (beats_in_frame == `CHANNEL_NUMBER - 1) else begin
                    protocol_errors++;
                    $display("Last flag came on beat %0d of a frame", beats_in_frame + 1);
                end
                beats_in_frame <= 0;
            end else begin
                assert (beats_in_frame < `CHANNEL_NUMBER - 1) else begin
                    protocol_errors++;
                    $display("Final beat of a frame came without the last flag");
                end
                beats_in_frame <= beats_in_frame + 1;
            end
        end
    end

    task automatic write_samples();
        logic [31:0] bits;
        for (int ch = 0; ch < `CHANNEL_NUMBER; ch++) begin
            random_bits(`SAMPLE_WIDTH, bits);
            @(negedge clock);
            sample_write = 1'b1;
            sample_channel = 2'(ch);
            sample_value = bits[`SAMPLE_WIDTH-1:0];
            source_samples[ch] = bits[`SAMPLE_WIDTH-1:0];
        end
        @(negedge clock);
        sample_write = 1'b0;
    endtask

    task automatic pulse_enable();
        @(negedge clock);
        enable = 1'b1;
        @(negedge clock);
        enable = 1'b0;
    endtask

    // The limit grows by one for every cycle spent with hold high
    task automatic wait_frame_done(input bit random_hold);
        int cycles;
        int limit;
        logic [31:0] bits;
        cycles = 0;
        limit = FRAME_TIMEOUT;
        while (!frame_done && cycles < limit) begin
            @(negedge clock);
            cycles++;
            if (random_hold) begin
                random_bits(1, bits);
                hold = bits[0];
            end
            if (hold) begin
                limit++;
            end
        end
        hold = 1'b0;
        if (!frame_done) begin
            timeout_errors++;
            $display("Timed out waiting for frame_done after %0d cycles", cycles);
        end
    endtask

    task automatic wait_beats(input int target_count);
        int cycles;
        cycles = 0;
        while (valid_count < target_count && cycles < BEAT_TIMEOUT) begin
            @(negedge clock);
            cycles++;
        end
        if (valid_count < target_count) begin
            timeout_errors++;
            $display("Timed out waiting for stream beat number %0d", target_count);
        end
    endtask

    // Reads every target channel back and compares it with the reference mapping
    task automatic check_targets(input sample_array_t samples);
        logic [`SAMPLE_WIDTH-1:0] expected;
        repeat (2) @(negedge clock);
        for (int ch = 0; ch < `CHANNEL_NUMBER; ch++) begin
            read_channel = 2'(ch);
            @(negedge clock);
            expected = expected_target(ch + 1, samples);
            assert (read_value === expected) else begin
                value_errors++;
                $display("[ERROR] read_value channel %0d: got %h expected %h",
                    ch + 1, read_value, expected);
            end
        end
    endtask

    initial begin
        clock = 1'b0;
        reset = 1'b0;
        enable = 1'b0;
        hold = 1'b0;
        sample_write = 1'b0;
        sample_channel = '0;
        sample_value = '0;
        read_channel = '0;
        lfsr_state = 32'h8661_dacf;
        value_errors = 0;
        protocol_errors = 0;
        timeout_errors = 0;
        valid_count = 0;
        beats_in_frame = 0;
        source_samples = '{default: '0};
        repeat (10) @(negedge clock);
        reset = 1'b1;

        // After reset nothing moves and the target bank is empty
        @(negedge clock);
        assert (!frame_done && !stream_valid && !stream_last) else begin
            protocol_errors++;
            $display("[ERROR] frame_done %h stream_valid %h stream_last %h: expected 0",
                frame_done, stream_valid, stream_last);
        end
        check_targets(source_samples);

        // One enable pulse moves one frame
        write_samples();
        count_before = valid_count;
        pulse_enable();
        wait_frame_done(1'b0);
        check_targets(source_samples);
        assert (valid_count - count_before == `CHANNEL_NUMBER) else begin
            protocol_errors++;
            $display("[ERROR] valid pulse count: got %h expected %h",
                valid_count - count_before, `CHANNEL_NUMBER);
        end

        // Two frames with enable held, samples rewritten after the first frame's reads
        write_samples();
        first_snapshot = source_samples;
        count_before = valid_count;
        @(negedge clock);
        enable = 1'b1;
        wait_beats(count_before + `CHANNEL_NUMBER - 1);
        repeat (2) @(negedge clock);
        // The last read has returned by now, so new samples only reach the second frame
        fork
            write_samples();
            wait_frame_done(1'b0);
        join
        check_targets(first_snapshot);
        enable = 1'b0;
        wait_frame_done(1'b0);
        check_targets(source_samples);

        // Random back-pressure stretches the frame
        write_samples();
        pulse_enable();
        wait_frame_done(1'b1);
        check_targets(source_samples);

        // Dropping enable mid-frame lets the frame finish and starts no other
        write_samples();
        count_before = valid_count;
        @(negedge clock);
        enable = 1'b1;
        wait_beats(count_before + 1);
        enable = 1'b0;
        wait_frame_done(1'b0);
        check_targets(source_samples);
        count_before = valid_count;
        repeat (40) @(negedge clock);
        assert (valid_count == count_before) else begin
            protocol_errors++;
            $display("A new frame started after enable was dropped");
        end

        $display("Errors: value %0d, protocol %0d, timeout %0d",
            value_errors, protocol_errors, timeout_errors);
        if (value_errors + protocol_errors + timeout_errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

    // Overall limit on simulation time
    initial begin
        #200000;
        $display("Simulation ran past its time limit");
        $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- tb.f
+incdir+.
dma_pkg.sv
channel_registers.sv
address_sequencer.sv
dma_control.sv
stream_packer.sv
target_registers.sv
sample_mover_top.sv
tb_sample_mover.sv

//--- run_sim.sh
#!/bin/sh
# Builds and runs the sample mover testbench with Verilator

verilator --binary --timing --assert -Wno-fatal -f tb.f \
    --top-module tb_sample_mover -o sim_sample_mover > build.log 2>&1 \
    && ./obj_dir/sim_sample_mover > sim.log 2>&1 \
    || { cat build.log sim.log 2>/dev/null; echo "Build or run failed"; exit 1; }

cat sim.log
grep -q "TESTBENCH FAILED" sim.log && exit 1 || exit 0
